// ==== logic/cq_cfg_pkg.sv ====
// Queue and memory side widths, address constants, vector types and read port structs
`default_nettype none

package cq_cfg_pkg;

    localparam int unsigned PPN_W           = 44;   // Base page number
    localparam int unsigned PLEN            = 56;   // Physical address
    localparam int unsigned IDX_W           = 32;   // Head and tail index
    localparam int unsigned LOG2SZ_W        = 5;    // log2(entries) - 1
    localparam int unsigned BEAT_W          = 64;
    localparam int unsigned ENTRY_W         = 128;  // One command is two beats
    localparam int unsigned PAGE_OFFS       = 12;
    localparam int unsigned ENTRY_OFFS      = 4;    // 16 bytes per entry
    localparam int unsigned MIN_MASK_LOG2SZ = 7;    // Head stays 8 bits wide up to here

    typedef logic [PPN_W-1:0]    ppn_t;
    typedef logic [PLEN-1:0]     paddr_t;
    typedef logic [IDX_W-1:0]    cq_idx_t;
    typedef logic [LOG2SZ_W-1:0] cq_log2sz_t;
    typedef logic [BEAT_W-1:0]   beat_t;
    typedef logic [ENTRY_W-1:0]  cq_entry_t;

    // Read request, held until granted
    typedef struct packed {
        logic   req;
        paddr_t addr;   // First beat address
    } cq_rd_req_t;

    typedef struct packed {
        logic  gnt;     // Request accepted
        logic  valid;   // One-cycle beat pulse
        logic  last;    // Second beat
        logic  err;     // Bus fault on this beat
        beat_t data;
    } cq_rd_rsp_t;

endpackage

`default_nettype wire

// ==== logic/cq_cmd_pkg.sv ====
// Command opcodes, function codes, command layouts, flush request and FSM states
`default_nettype none

package cq_cmd_pkg;

    localparam int unsigned DID_W   = 24;
    localparam int unsigned PID_W   = 20;
    localparam int unsigned PSCID_W = 20;
    localparam int unsigned GSCID_W = 16;
    localparam int unsigned VPN_W   = 52;   // ADDR[63:12]

    typedef logic [DID_W-1:0]   did_t;
    typedef logic [PID_W-1:0]   pid_t;
    typedef logic [PSCID_W-1:0] pscid_t;
    typedef logic [GSCID_W-1:0] gscid_t;
    typedef logic [VPN_W-1:0]   vpn_t;

    typedef enum logic [6:0] {
        IOTINVAL = 7'd1,
        IOFENCE  = 7'd2,
        IODIR    = 7'd3,
        ATS      = 7'd4
    } cq_opcode_e;

    // func3 in bits 9:7
    localparam logic [2:0] VMA  = 3'd0;
    localparam logic [2:0] GVMA = 3'd1;
    localparam logic [2:0] DDT  = 3'd0;
    localparam logic [2:0] PDT  = 3'd1;

    typedef struct packed {
        logic [1:0]  rsvd_4;    // 127:126
        vpn_t        addr;      // 125:74
        logic [9:0]  rsvd_3;    // 73:64
        logic [3:0]  rsvd_2;    // 63:60
        gscid_t      gscid;     // 59:44
        logic [9:0]  rsvd_1;    // 43:34
        logic        gv;
        logic        pscv;
        pscid_t      pscid;     // 31:12
        logic        rsvd_0;
        logic        av;
        logic [2:0]  func3;
        cq_opcode_e  opcode;
    } cq_iotinval_t;

    typedef struct packed {
        logic [61:0] addr;      // ADDR[63:2], no memory write in this design
        logic [1:0]  rsvd_1;    // 65:64
        logic [31:0] data;
        logic [17:0] rsvd_0;    // 31:14
        logic        pw;
        logic        pr;
        logic        wsi;       // Raise fence_w_ip on completion
        logic        av;
        logic [2:0]  func3;
        cq_opcode_e  opcode;
    } cq_iofence_t;

    typedef struct packed {
        logic [63:0] rsvd_3;    // Whole second dword
        did_t        did;       // 63:40
        logic [5:0]  rsvd_2;
        logic        dv;        // 33
        logic        rsvd_1;
        pid_t        pid;       // 31:12
        logic [1:0]  rsvd_0;
        logic [2:0]  func3;
        cq_opcode_e  opcode;
    } cq_iodirinval_t;

    // Invalidation request towards IOTLB, DDTC and PDTC
    typedef struct packed {
        logic   vma;
        logic   gvma;
        logic   ddtc;
        logic   pdtc;
        logic   av;
        logic   gv;
        logic   pscv;
        logic   dv;
        logic   pv;
        vpn_t   vpn;
        gscid_t gscid;
        pscid_t pscid;
        did_t   did;
        pid_t   pid;
    } cq_flush_t;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        REGISTER,
        DECODE,
        ERROR
    } cq_state_e;

endpackage

`default_nettype wire

// ==== logic/cq_head_counter.sv ====
// Head index register with size masking, empty check and fetch address generation
`timescale 1ns/1ps
`default_nettype none

module cq_head_counter (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   clr_i,         // Enable rising edge
    input  logic                   inc_i,         // Last beat accepted
    input  cq_cfg_pkg::cq_log2sz_t size_i,
    input  cq_cfg_pkg::ppn_t       base_ppn_i,
    input  cq_cfg_pkg::cq_idx_t    tail_i,
    output cq_cfg_pkg::cq_idx_t    head_o,        // Masked to the queue size
    output cq_cfg_pkg::paddr_t     fetch_addr_o,
    output logic                   not_empty_o
);
    import cq_cfg_pkg::*;

    cq_idx_t           head_q;
    cq_idx_t           size_mask;
    logic [LOG2SZ_W:0] idx_bits;    // log2(entries), one bit wider so size 31 fits

    assign idx_bits = size_i + 1'b1;

    // Small queues still keep a full byte of head
    assign size_mask = (size_i <= LOG2SZ_W'(MIN_MASK_LOG2SZ)) ? cq_idx_t'(8'hff)
                                                              : ~({IDX_W{1'b1}} << idx_bits);

    assign head_o      = head_q & size_mask;
    assign not_empty_o = (tail_i != head_o);    // Software has queued more

    // Base page plus 16 bytes per entry
    assign fetch_addr_o = {base_ppn_i, PAGE_OFFS'(0)} | paddr_t'({head_o, ENTRY_OFFS'(0)});

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            head_q <= '0;
        end else if (clr_i) begin
            head_q <= '0;
        end else if (inc_i) begin
            head_q <= (head_o + 1'b1) & size_mask;  // Wraps at the queue end
        end
    end

    // FSM never clears and advances in one cycle
    assert property (@(posedge clk_i) disable iff (!rst_ni) !(clr_i && inc_i))
        else $error("head counter cleared and incremented together");

endmodule

`default_nettype wire

// ==== logic/cq_entry_buffer.sv ====
// Command entry register assembled from two read beats
`timescale 1ns/1ps
`default_nettype none

module cq_entry_buffer (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  capture_i,
    input  cq_cfg_pkg::beat_t     beat_i,
    input  logic                  last_i,
    output cq_cfg_pkg::cq_entry_t entry_o
);
    import cq_cfg_pkg::*;

    cq_entry_t entry_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            entry_q <= '0;
        end else if (capture_i) begin
            if (last_i) begin
                entry_q[ENTRY_W-1:BEAT_W] <= beat_i;    // Second dword
            end else begin
                entry_q[BEAT_W-1:0] <= beat_i;
            end
        end
    end

    assign entry_o = entry_q;   // Held through DECODE

endmodule

`default_nettype wire

// ==== logic/cq_cmd_decoder.sv ====
// Command decoder producing flush requests, the fence flag set and the illegal flag
`timescale 1ns/1ps
`default_nettype none

module cq_cmd_decoder (
    input  cq_cfg_pkg::cq_entry_t entry_i,
    input  logic                  decode_i,      // Entry complete and head advanced
    input  logic                  wsi_en_i,
    output cq_cmd_pkg::cq_flush_t flush_o,
    output logic                  ill_o,
    output logic                  fence_set_o
);
    import cq_cmd_pkg::*;

    cq_iotinval_t   inv;
    cq_iofence_t    fence;
    cq_iodirinval_t dir;

    // Same bits, three views
    assign inv   = cq_iotinval_t'(entry_i);
    assign fence = cq_iofence_t'(entry_i);
    assign dir   = cq_iodirinval_t'(entry_i);

    always_comb begin
        flush_o     = '0;
        ill_o       = 1'b0;
        fence_set_o = 1'b0;
        if (decode_i) begin
            case (inv.opcode)
                IOTINVAL: begin
                    // Reserved bits, or PSCV with GVMA
                    if (|{inv.rsvd_0, inv.rsvd_1, inv.rsvd_2, inv.rsvd_3, inv.rsvd_4} ||
                        (inv.func3 == GVMA && inv.pscv)) begin
                        ill_o = 1'b1;
                    end else if (inv.func3 == VMA) begin
                        flush_o.vma   = 1'b1;     // First stage entries
                        flush_o.pscv  = inv.pscv;
                        flush_o.pscid = inv.pscid;
                    end else if (inv.func3 == GVMA) begin
                        flush_o.gvma = 1'b1;      // Second stage entries
                    end
                    if (flush_o.vma || flush_o.gvma) begin
                        flush_o.av    = inv.av;
                        flush_o.gv    = inv.gv;
                        flush_o.vpn   = inv.addr;
                        flush_o.gscid = inv.gscid;
                    end
                end
                IOFENCE: begin
                    if (|{fence.rsvd_0, fence.rsvd_1}) begin
                        ill_o = 1'b1;
                    end else begin
                        fence_set_o = fence.wsi & wsi_en_i;   // Only with wired interrupts
                    end
                end
                IODIR: begin
                    // PID is reserved for INVAL_DDT
                    if (|{dir.rsvd_0, dir.rsvd_1, dir.rsvd_2, dir.rsvd_3} ||
                        (dir.func3 == DDT && |dir.pid)) begin
                        ill_o = 1'b1;
                    end else if (dir.func3 == DDT) begin
                        flush_o.ddtc = 1'b1;
                        flush_o.pdtc = 1'b1;    // Process tables hang off the device entry
                    end else if (dir.func3 == PDT) begin
                        flush_o.pdtc = 1'b1;
                        flush_o.pv   = 1'b1;
                        flush_o.pid  = dir.pid;
                    end
                    if (flush_o.pdtc) begin
                        flush_o.dv  = dir.dv;
                        flush_o.did = dir.did;
                    end
                end
                ATS: ;                          // Retires as a no-op
                default: ill_o = 1'b1;          // Reserved opcode
            endcase
        end
    end

    // Illegal commands never reach the caches
    always_comb begin
        assert (!(ill_o && |{flush_o.vma, flush_o.gvma, flush_o.ddtc, flush_o.pdtc}))
            else $error("flush strobe on an illegal command");
    end

endmodule

`default_nettype wire

// ==== logic/cq_status_flags.sv ====
// Sticky fault, illegal and fence flags with clear, interrupt pending and error pending
`timescale 1ns/1ps
`default_nettype none

module cq_status_flags (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic clr_i,          // Software clear or enable rising edge
    input  logic mf_set_i,
    input  logic ill_set_i,
    input  logic fence_set_i,
    input  logic ie_i,
    output logic mf_o,
    output logic ill_o,
    output logic fence_o,
    output logic ip_o,
    output logic err_pending_o   // Holds the FSM in ERROR
);
    logic mf_q;
    logic ill_q;
    logic fence_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mf_q    <= 1'b0;
            ill_q   <= 1'b0;
            fence_q <= 1'b0;
        end else if (clr_i) begin
            mf_q    <= 1'b0;
            ill_q   <= 1'b0;
            fence_q <= 1'b0;
        end else begin
            mf_q    <= mf_q | mf_set_i;         // Sticky until cleared
            ill_q   <= ill_q | ill_set_i;
            fence_q <= fence_q | fence_set_i;
        end
    end

    assign mf_o          = mf_q;
    assign ill_o         = ill_q;
    assign fence_o       = fence_q;
    assign ip_o          = (mf_q | ill_q | fence_q) & ie_i;
    assign err_pending_o = mf_q | ill_q;        // Fence completion is not an error

endmodule

`default_nettype wire

// ==== logic/cq_fsm.sv ====
// Command queue FSM for enable tracking, fetch, beat register, decode and error stop
`timescale 1ns/1ps
`default_nettype none

module cq_fsm (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   en_i,
    input  logic                   not_empty_i,
    input  logic                   err_pending_i,
    input  logic                   ill_i,
    input  cq_cfg_pkg::paddr_t     fetch_addr_i,
    input  cq_cfg_pkg::cq_rd_rsp_t rd_rsp_i,
    output cq_cfg_pkg::cq_rd_req_t rd_req_o,
    output logic                   busy_o,
    output logic                   on_o,
    output logic                   en_rise_o,
    output logic                   head_inc_o,
    output logic                   capture_o,
    output logic                   decode_o,
    output logic                   mf_set_o
);
    import cq_cfg_pkg::*;
    import cq_cmd_pkg::*;

    cq_state_e state_q;
    cq_state_e state_n;
    logic      en_q;
    paddr_t    addr_q;
    logic      drain_q;     // Second beat still owed after a fault on the first
    logic      drain_n;

    assign busy_o    = (en_i != en_q);   // One cycle after each toggle
    assign on_o      = en_i | en_q;
    assign en_rise_o = en_i & ~en_q;

    assign rd_req_o.req  = (state_q == FETCH);
    assign rd_req_o.addr = addr_q;

    always_comb begin
        state_n    = state_q;
        drain_n    = drain_q;
        head_inc_o = 1'b0;
        capture_o  = 1'b0;
        decode_o   = 1'b0;
        mf_set_o   = 1'b0;
        case (state_q)
            IDLE: begin
                // Enable must already be registered, so a fresh enable clears first
                if (en_i && en_q && not_empty_i) begin
                    state_n = FETCH;
                end
            end
            FETCH: begin
                if (rd_rsp_i.gnt) begin
                    state_n = REGISTER;
                end
            end
            REGISTER: begin
                capture_o = rd_rsp_i.valid;
                if (rd_rsp_i.valid) begin
                    if (rd_rsp_i.err) begin
                        mf_set_o = 1'b1;            // Head stays on this entry
                        drain_n  = !rd_rsp_i.last;
                        state_n  = ERROR;
                    end else if (rd_rsp_i.last) begin
                        head_inc_o = 1'b1;
                        state_n    = DECODE;
                    end
                end
            end
            DECODE: begin
                decode_o = 1'b1;                    // Flush strobes pulse here
                state_n  = ill_i ? ERROR : IDLE;
            end
            ERROR: begin
                // Beats are dropped here
                if (rd_rsp_i.valid && rd_rsp_i.last) begin
                    drain_n = 1'b0;
                end
                if (!err_pending_i && !drain_q) begin
                    state_n = IDLE;
                end
            end
            default: state_n = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            en_q    <= 1'b0;
            drain_q <= 1'b0;
        end else begin
            state_q <= state_n;
            en_q    <= en_i;
            drain_q <= drain_n;
        end
    end

    // Entry address frozen for the whole request
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            addr_q <= '0;
        end else if (state_q == IDLE && state_n == FETCH) begin
            addr_q <= fetch_addr_i;
        end
    end

    // Memory grants only a held request
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        rd_rsp_i.gnt |-> rd_req_o.req)
        else $error("read grant without a request");

    // Memory only returns beats for an accepted request
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        rd_rsp_i.valid |-> state_q inside {REGISTER, ERROR})
        else $error("read beat outside a transfer");

endmodule

`default_nettype wire

// ==== logic/cq_handler_top.sv ====
// Command queue handler top with FSM, head counter, entry buffer, decoder and flags
`timescale 1ns/1ps
`default_nettype none

module cq_handler_top (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    // Software registers
    input  cq_cfg_pkg::ppn_t       cq_base_ppn_i,
    input  cq_cfg_pkg::cq_log2sz_t cq_size_i,
    input  logic                   cq_en_i,
    input  logic                   cq_ie_i,
    input  cq_cfg_pkg::cq_idx_t    cq_tail_i,
    input  logic                   wsi_en_i,
    input  logic                   err_clr_i,      // Clears all flags
    // Status
    output cq_cfg_pkg::cq_idx_t    cq_head_o,
    output logic                   cq_on_o,
    output logic                   busy_o,
    output logic                   cq_mf_o,
    output logic                   cmd_ill_o,
    output logic                   fence_w_ip_o,
    output logic                   cq_ip_o,
    // Memory read port
    output cq_cfg_pkg::cq_rd_req_t mem_req_o,
    input  cq_cfg_pkg::cq_rd_rsp_t mem_rsp_i,
    // Cache invalidation
    output cq_cmd_pkg::cq_flush_t  flush_o
);
    import cq_cfg_pkg::*;

    paddr_t    fetch_addr;
    cq_entry_t entry;
    logic      en_rise;
    logic      head_inc;
    logic      capture;
    logic      decode;
    logic      not_empty;
    logic      err_pending;
    logic      mf_set;
    logic      ill_set;
    logic      fence_set;

    cq_fsm u_fsm (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .en_i          (cq_en_i),
        .not_empty_i   (not_empty),
        .err_pending_i (err_pending),
        .ill_i         (ill_set),
        .fetch_addr_i  (fetch_addr),
        .rd_rsp_i      (mem_rsp_i),
        .rd_req_o      (mem_req_o),
        .busy_o        (busy_o),
        .on_o          (cq_on_o),
        .en_rise_o     (en_rise),
        .head_inc_o    (head_inc),
        .capture_o     (capture),
        .decode_o      (decode),
        .mf_set_o      (mf_set)
    );

    cq_head_counter u_head (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .clr_i        (en_rise),
        .inc_i        (head_inc),
        .size_i       (cq_size_i),
        .base_ppn_i   (cq_base_ppn_i),
        .tail_i       (cq_tail_i),
        .head_o       (cq_head_o),
        .fetch_addr_o (fetch_addr),
        .not_empty_o  (not_empty)
    );

    cq_entry_buffer u_entry (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .capture_i (capture),
        .beat_i    (mem_rsp_i.data),
        .last_i    (mem_rsp_i.last),
        .entry_o   (entry)
    );

    cq_cmd_decoder u_decoder (
        .entry_i     (entry),
        .decode_i    (decode),
        .wsi_en_i    (wsi_en_i),
        .flush_o     (flush_o),
        .ill_o       (ill_set),
        .fence_set_o (fence_set)
    );

    // Flags also clear when the queue is enabled
    cq_status_flags u_flags (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .clr_i         (err_clr_i | en_rise),
        .mf_set_i      (mf_set),
        .ill_set_i     (ill_set),
        .fence_set_i   (fence_set),
        .ie_i          (cq_ie_i),
        .mf_o          (cq_mf_o),
        .ill_o         (cmd_ill_o),
        .fence_o       (fence_w_ip_o),
        .ip_o          (cq_ip_o),
        .err_pending_o (err_pending)
    );

endmodule

`default_nettype wire

// ==== verification/cq_mem_model.svh ====
// Command memory with random contents, read port server with delays and faults, reference decoder
`ifndef CQ_MEM_MODEL_SVH
`define CQ_MEM_MODEL_SVH

    localparam int unsigned MEM_ENTRIES = 512;  // Covers the 9-bit head of size 8

    cq_entry_t cmd_mem [0:MEM_ENTRIES-1];

    // Random command of a random opcode, mostly with clean reserved fields
    task automatic build_command(output cq_entry_t e);
        int unsigned kind;
        logic        clean;
        e     = {$random(seed), $random(seed), $random(seed), $random(seed)};
        kind  = $unsigned($random(seed)) % 10;
        clean = ($unsigned($random(seed)) % 5) != 0;
        e[9:8] = 2'b00;                             // func3 is 0 or 1
        case (kind)
            0, 1, 2: e[6:0] = 7'd1;                 // IOTINVAL
            3, 4:    e[6:0] = 7'd3;                 // IODIR
            5, 6:    e[6:0] = 7'd2;                 // IOFENCE
            7, 8:    e[6:0] = 7'd4;                 // ATS
            default: e[6:0] = 7'(5 + $unsigned($random(seed)) % 100);  // Unknown
        endcase
        if (clean && e[6:0] == 7'd1) begin
            e[11]      = 1'b0;
            e[43:34]   = '0;
            e[63:60]   = '0;
            e[73:64]   = '0;
            e[127:126] = '0;
            if (e[7] && ($unsigned($random(seed)) % 4) != 0) e[32] = 1'b0;  // Mostly no PSCV on GVMA
        end
        if (clean && e[6:0] == 7'd3) begin
            e[11:10]  = '0;
            e[32]     = 1'b0;
            e[39:34]  = '0;
            e[127:64] = '0;
            if (!e[7] && ($unsigned($random(seed)) % 4) != 0) e[31:12] = '0;  // PID kept on some DDT
        end
        if (clean && e[6:0] == 7'd2) begin
            e[31:14] = '0;
            e[65:64] = '0;
        end
    endtask

    task automatic fill_queue_memory;
        for (int i = 0; i < MEM_ENTRIES; i++) begin
            build_command(cmd_mem[i]);
        end
    endtask

    // Waits for the request, grants after 0 to 3 cycles and returns two beats with gaps
    task automatic serve_fetch(input cq_idx_t idx, input logic inject, input logic err_beat);
        int unsigned delay;
        int unsigned gap;
        paddr_t      exp_addr;
        exp_addr = (paddr_t'(cq_base_ppn_i) << 12) | (paddr_t'(idx) << 4);
        while (!mem_req_o.req) @(negedge clk_i);
        compare_value("mem_req_o.addr", 256'(mem_req_o.addr), 256'(exp_addr));
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) @(negedge clk_i);
        mem_rsp_i.gnt = 1'b1;
        @(negedge clk_i);
        mem_rsp_i.gnt = 1'b0;
        for (int b = 0; b < 2; b++) begin
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) @(negedge clk_i);
            mem_rsp_i.valid = 1'b1;
            mem_rsp_i.last  = (b == 1);
            mem_rsp_i.err   = inject && (b == int'(err_beat));
            mem_rsp_i.data  = (b == 1) ? cmd_mem[idx][127:64] : cmd_mem[idx][63:0];
            @(negedge clk_i);
            mem_rsp_i.valid = 1'b0;
            mem_rsp_i.last  = 1'b0;
            mem_rsp_i.err   = 1'b0;
        end
    endtask

    // Expected flush, illegal and fence set for one entry, from the spec bit positions
    task automatic model_decode(input cq_entry_t e, input logic wsi, output cq_flush_t f,
                                output logic ill, output logic fence);
        logic [6:0] op;
        logic [2:0] f3;
        op    = e[6:0];
        f3    = e[9:7];
        f     = '0;
        ill   = 1'b0;
        fence = 1'b0;
        if (op == 7'd1) begin
            if (e[11] || |e[43:34] || |e[63:60] || |e[73:64] || |e[127:126] ||
                (f3 == 3'd1 && e[32])) begin
                ill = 1'b1;
            end else if (f3 == 3'd0 || f3 == 3'd1) begin
                f.vma   = (f3 == 3'd0);
                f.gvma  = (f3 == 3'd1);
                f.av    = e[10];
                f.gv    = e[33];
                f.vpn   = e[125:74];
                f.gscid = e[59:44];
                if (f3 == 3'd0) begin
                    f.pscv  = e[32];
                    f.pscid = e[31:12];
                end
            end
        end else if (op == 7'd2) begin
            if (|e[31:14] || |e[65:64]) ill = 1'b1;
            else fence = e[11] & wsi;                  // WSI only counts when enabled
        end else if (op == 7'd3) begin
            if (|e[11:10] || e[32] || |e[39:34] || |e[127:64] ||
                (f3 == 3'd0 && |e[31:12])) begin
                ill = 1'b1;
            end else if (f3 == 3'd0 || f3 == 3'd1) begin
                f.ddtc = (f3 == 3'd0);
                f.pdtc = 1'b1;
                f.dv   = e[33];
                f.did  = e[63:40];
                if (f3 == 3'd1) begin
                    f.pv  = 1'b1;
                    f.pid = e[31:12];
                end
            end
        end else if (op != 7'd4) begin
            ill = 1'b1;                                 // ATS retires silently
        end
    endtask

`endif

// ==== verification/cq_handler_tb.sv ====
// Testbench for the command queue handler with clock, reset, random commands, checks and watchdog
`timescale 1ns/1ps
`default_nettype none

module cq_handler_tb;
    import cq_cfg_pkg::*;
    import cq_cmd_pkg::*;

    localparam int unsigned N_PHASE0 = 270;    // Size 7, wraps at 256
    localparam int unsigned N_PHASE1 = 300;    // Size 8, 9-bit head passes 255
    localparam int unsigned N_TOTAL  = N_PHASE0 + N_PHASE1;

    logic       clk_i;
    logic       rst_ni;
    ppn_t       cq_base_ppn_i;
    cq_log2sz_t cq_size_i;
    logic       cq_en_i;
    logic       cq_ie_i;
    cq_idx_t    cq_tail_i;
    logic       wsi_en_i;
    logic       err_clr_i;
    cq_idx_t    cq_head_o;
    logic       cq_on_o;
    logic       busy_o;
    logic       cq_mf_o;
    logic       cmd_ill_o;
    logic       fence_w_ip_o;
    logic       cq_ip_o;
    cq_rd_req_t mem_req_o;
    cq_rd_rsp_t mem_rsp_i;
    cq_flush_t  flush_o;

    integer      seed = 8;
    int unsigned checks;
    int unsigned errors;
    int unsigned flush_seen;    // Strobe cycles seen on flush_o
    int unsigned flush_exp;
    cq_idx_t     exp_head;
    cq_idx_t     head_mask;
    logic        mf_m;          // Model flags
    logic        ill_m;
    logic        fence_m;

    task automatic compare_value(input string name, input logic [255:0] got,
                                 input logic [255:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    `include "cq_mem_model.svh"

    cq_handler_top dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    function automatic logic any_strobe(input cq_flush_t f);
        return f.vma | f.gvma | f.ddtc | f.pdtc;
    endfunction

    // Counts every strobe cycle so stray pulses show up in the total
    always @(negedge clk_i) begin
        if (rst_ni && any_strobe(flush_o)) flush_seen++;
    end

    initial begin
        repeat (200 * N_TOTAL + 1000) @(posedge clk_i);
        $display("Watchdog expired before all commands were handled");
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic check_flags;
        compare_value("cq_mf_o", 256'(cq_mf_o), 256'(mf_m));
        compare_value("cmd_ill_o", 256'(cmd_ill_o), 256'(ill_m));
        compare_value("fence_w_ip_o", 256'(fence_w_ip_o), 256'(fence_m));
        compare_value("cq_ip_o", 256'(cq_ip_o), 256'((mf_m | ill_m | fence_m) & cq_ie_i));
    endtask

    // Queue must stay stopped until software clears the flags
    task automatic resolve_error;
        repeat (4) begin
            @(negedge clk_i);
            checks++;
            if (mem_req_o.req) begin
                errors++;
                $display("Read request issued at %0t while an error was pending", $time);
            end
        end
        err_clr_i = 1'b1;
        @(negedge clk_i);
        err_clr_i = 1'b0;
        mf_m      = 1'b0;
        ill_m     = 1'b0;
        fence_m   = 1'b0;
        check_flags();
    endtask

    task automatic set_enable(input logic en);
        cq_en_i = en;
        #1;
        compare_value("busy_o", 256'(busy_o), 256'(1));
        compare_value("cq_on_o", 256'(cq_on_o), 256'(1));
        @(negedge clk_i);
        compare_value("busy_o", 256'(busy_o), 256'(0));
        compare_value("cq_on_o", 256'(cq_on_o), 256'(en));
    endtask

    // One entry at the model head, refetched after injected beat faults
    task automatic run_command;
        cq_entry_t e;
        cq_idx_t   idx;
        cq_flush_t f_exp;
        logic      ill_e;
        logic      fence_e;
        logic      inject;
        logic      done;
        idx      = exp_head;
        e        = cmd_mem[idx];
        cq_ie_i  = 1'($random(seed));
        wsi_en_i = 1'($random(seed));
        done     = 1'b0;
        while (!done) begin
            inject = ($unsigned($random(seed)) % 10) == 0;
            serve_fetch(idx, inject, 1'($random(seed)));
            if (inject) begin
                compare_value("flush strobes", 256'(any_strobe(flush_o)), 256'(0));
                compare_value("cq_head_o", 256'(cq_head_o), 256'(idx));
                @(negedge clk_i);
                mf_m = 1'b1;
                check_flags();
                resolve_error();
            end else begin
                done = 1'b1;
            end
        end
        model_decode(e, wsi_en_i, f_exp, ill_e, fence_e);
        compare_value("flush_o", 256'(flush_o), 256'(f_exp));   // DECODE cycle
        exp_head = (exp_head + 1) & head_mask;
        compare_value("cq_head_o", 256'(cq_head_o), 256'(exp_head));
        if (any_strobe(f_exp)) flush_exp++;
        @(negedge clk_i);
        compare_value("flush strobes", 256'(any_strobe(flush_o)), 256'(0));
        ill_m   = ill_m | ill_e;
        fence_m = fence_m | fence_e;
        check_flags();
        if (ill_e) resolve_error();
    endtask

    task automatic run_phase(input cq_log2sz_t size, input ppn_t base, input int unsigned n);
        int unsigned left;
        int unsigned k;
        cq_size_i     = size;
        cq_base_ppn_i = base;
        cq_tail_i     = '0;
        head_mask     = (size <= 5'd7) ? 32'hff : cq_idx_t'((64'd1 << (int'(size) + 1)) - 1);
        set_enable(1'b1);
        exp_head = '0;
        mf_m     = 1'b0;
        ill_m    = 1'b0;
        fence_m  = 1'b0;
        compare_value("cq_head_o", 256'(cq_head_o), 256'(0));
        check_flags();
        left = n;
        while (left > 0) begin
            k = 1 + $unsigned($random(seed)) % 8;  // Batch of queued commands
            if (k > left) k = left;
            cq_tail_i = (exp_head + k) & head_mask;
            repeat (k) run_command();
            left = left - k;
        end
        set_enable(1'b0);
    endtask

    initial begin
        rst_ni        = 1'b0;
        cq_base_ppn_i = '0;
        cq_size_i     = '0;
        cq_en_i       = 1'b0;
        cq_ie_i       = 1'b0;
        cq_tail_i     = '0;
        wsi_en_i      = 1'b0;
        err_clr_i     = 1'b0;
        mem_rsp_i     = '0;
        checks        = 0;
        errors        = 0;
        flush_seen    = 0;
        flush_exp     = 0;
        fill_queue_memory();
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        @(negedge clk_i);
        run_phase(5'd7, 44'h00ab_cdef_123, N_PHASE0);
        run_phase(5'd8, 44'h5a5_a0f0_f3c0, N_PHASE1);
        @(negedge clk_i);
        compare_value("flush pulse count", 256'(flush_seen), 256'(flush_exp));
        $display("Summary: %0d checks, %0d errors, %0d flush pulses", checks, errors, flush_seen);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+verification
logic/cq_cfg_pkg.sv
logic/cq_cmd_pkg.sv
logic/cq_head_counter.sv
logic/cq_entry_buffer.sv
logic/cq_cmd_decoder.sv
logic/cq_status_flags.sv
logic/cq_fsm.sv
logic/cq_handler_top.sv
verification/cq_handler_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it; exit status 0 only on a passing run

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f verilog.f --top-module cq_handler_tb \
    -o cq_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Build failed, see build.log"
    exit 1
fi

./obj_dir/cq_sim > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status, see sim.log"
    exit 1
fi

if grep -qx "ALL CHECKS PASSED" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL, see sim.log"
    exit 1
fi
